/* Bender.yml */
package:
  name: sobel_edge

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sobel_pkg.sv
      - verilog/line_window.sv
      - verilog/grad_conv.sv
      - verilog/grad_magnitude.sv
      - verilog/sobel_edge_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/sobel_edge_assert.sv
      - test/sobel_edge_tb.sv

/* sobel_edge.f */
+incdir+verilog
verilog/sobel_pkg.sv
verilog/line_window.sv
verilog/grad_conv.sv
verilog/grad_magnitude.sv
verilog/sobel_edge_top.sv
test/sobel_edge_assert.sv
test/sobel_edge_tb.sv

/* test/sobel_edge_assert.sv */
module sobel_edge_assert import sobel_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic result_valid,
	input logic done,
	input edge_result_t result
);

	int abs_sum;

	function automatic int abs_grad(grad_t g);
		return (g < 0) ? -int'(g) : int'(g);
	endfunction

	assign abs_sum = abs_grad(result.gx) + abs_grad(result.gy);

	// ----------------------------------------
	// port rules
	// ----------------------------------------

	done_with_valid: assert property (@(posedge clk) disable iff (rst)
		done |-> result_valid) else $error("done high without result_valid");

	quiet_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> (!result_valid && !done)) else $error("output strobe high after reset");

	// the clipped magnitude must show full scale for large sums.
	magnitude_saturates: assert property (@(posedge clk) disable iff (rst)
		(result_valid && abs_sum > 255) |-> (result.magnitude == 8'hff))
		else $error("magnitude not saturated");

	busy_needs_start: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(start)) else $error("busy rose without start");

endmodule

bind sobel_edge_top sobel_edge_assert u_checks (
	.clk(clk),
	.rst(rst),
	.start(start),
	.busy(busy),
	.result_valid(result_valid),
	.done(done),
	.result(result)
);

/* test/sobel_edge_tb.sv */
`include "sobel_macros.svh"

module sobel_edge_tb import sobel_pkg::*; ();

	localparam int W = `SOBEL_IMG_WIDTH;
	localparam int H = `SOBEL_IMG_HEIGHT;
	localparam int BEATS = (W - 2) * (H - 2);
	localparam int NUM_TESTS = 8;

	typedef enum logic [2:0] {IMG_FLAT, IMG_VSTEP, IMG_HSTEP, IMG_RAMP, IMG_NOISE} img_kind_t;

	typedef struct packed {
		img_kind_t kind;
		logic [10:0] threshold;
		int gap_pct;     // chance in percent of an idle cycle before each pixel.
		int idle_pix;    // pixels offered while the DUT is idle.
	} test_row_t;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic pixel_valid;
	pixel_t pixel_in;
	logic [10:0] threshold;
	edge_result_t result;
	logic result_valid;
	logic done;
	logic busy;

	test_row_t tests [NUM_TESTS];
	pixel_t img [H][W];
	edge_result_t exp_q [$];
	logic [31:0] rng = 32'd66231;
	int errors = 0;
	int errors_mark = 0;
	int pass_count = 0;
	int fail_count = 0;
	int frames_done = 0;
	int beat_idx = 0;
	int cycles = 0;
	int cycle_limit = 0;

	sobel_edge_top uut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.threshold(threshold),
		.result(result),
		.result_valid(result_valid),
		.done(done),
		.busy(busy)
	);

	always #20 clk = ~clk;

	// ----------------------------------------
	// helpers and reference model
	// ----------------------------------------

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int pix(int x, int y);
		return int'(img[y][x]);
	endfunction

	// gradients of the neighbourhood centred on (cx, cy).
	function automatic edge_result_t expect_at(int cx, int cy, logic [10:0] thr);
		int gx;
		int gy;
		int sum;
		edge_result_t r;
		gx = pix(cx + 1, cy - 1) + 2 * pix(cx + 1, cy) + pix(cx + 1, cy + 1);
		gx = gx - pix(cx - 1, cy - 1) - 2 * pix(cx - 1, cy) - pix(cx - 1, cy + 1);
		gy = pix(cx - 1, cy + 1) + 2 * pix(cx, cy + 1) + pix(cx + 1, cy + 1);
		gy = gy - pix(cx - 1, cy - 1) - 2 * pix(cx, cy - 1) - pix(cx + 1, cy - 1);
		sum = ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
		r.gx = grad_t'(gx);
		r.gy = grad_t'(gy);
		r.magnitude = (sum > 255) ? 8'hff : 8'(sum);
		r.is_edge = (sum >= int'(thr));   // compared before clipping.
		return r;
	endfunction

	task automatic build_image(input img_kind_t kind, input logic [10:0] thr);
		logic [31:0] r;
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				case (kind)
					IMG_FLAT: img[y][x] = 8'd77;
					IMG_VSTEP: img[y][x] = (x < W / 2) ? 8'd20 : 8'd220;
					IMG_HSTEP: img[y][x] = (y < H / 2) ? 8'd30 : 8'd200;
					IMG_RAMP: img[y][x] = 8'(128 + 3 * y - 3 * x);   // falls left to right.
					default: begin
						r = next_rand();
						img[y][x] = r[7] ? {4'hf, r[3:0]} : {4'h0, r[3:0]};
					end
				endcase
			end
		end
		for (int cy = 1; cy < H - 1; cy++) begin
			for (int cx = 1; cx < W - 1; cx++) begin
				exp_q.push_back(expect_at(cx, cy, thr));
			end
		end
	endtask

	task automatic check_result(input edge_result_t got, input edge_result_t exp, input int idx);
		if (got.gx !== exp.gx) begin
			$display("mismatch result.gx beat %0d: got 0x%h expected 0x%h", idx, got.gx, exp.gx);
			errors++;
		end
		if (got.gy !== exp.gy) begin
			$display("mismatch result.gy beat %0d: got 0x%h expected 0x%h", idx, got.gy, exp.gy);
			errors++;
		end
		if (got.magnitude !== exp.magnitude) begin
			$display("mismatch result.magnitude beat %0d: got 0x%h expected 0x%h",
				idx, got.magnitude, exp.magnitude);
			errors++;
		end
		if (got.is_edge !== exp.is_edge) begin
			$display("mismatch result.is_edge beat %0d: got 0x%h expected 0x%h",
				idx, got.is_edge, exp.is_edge);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#5;
	endtask

	// ----------------------------------------
	// frame driver
	// ----------------------------------------

	task automatic run_frame(input int t);
		// results still in flight use the threshold, so a new one waits for them.
		if (t > 0 && tests[t].threshold != threshold) begin
			while (frames_done < t) step();
		end
		build_image(tests[t].kind, tests[t].threshold);
		threshold = tests[t].threshold;
		for (int i = 0; i < tests[t].idle_pix; i++) begin
			pixel_valid = 1'b1;
			pixel_in = pixel_t'(next_rand());
			step();
		end
		pixel_valid = 1'b0;
		check_flag("busy", busy, 1'b0);
		start = 1'b1;
		step();
		start = 1'b0;
		check_flag("busy", busy, 1'b1);
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				while ((next_rand() % 100) < tests[t].gap_pct) begin
					pixel_valid = 1'b0;
					step();
				end
				pixel_valid = 1'b1;
				pixel_in = img[y][x];
				step();
			end
		end
		pixel_valid = 1'b0;
		check_flag("busy", busy, 1'b0);   // falls with the last accepted pixel.
	endtask

	// ----------------------------------------
	// monitor
	// ----------------------------------------

	task automatic report_frame();
		if (frames_done >= NUM_TESTS) begin
			$display("done pulsed with no frame running");
			errors++;
		end else begin
			if (beat_idx != BEATS) begin
				$display("frame %0d ended after %0d result beats instead of %0d",
					frames_done, beat_idx, BEATS);
				errors++;
			end
			if (errors == errors_mark) pass_count++;
			else fail_count++;
			$display("test %0d %s threshold %0d: %0d beats, %0d errors", frames_done,
				tests[frames_done].kind.name(), tests[frames_done].threshold,
				beat_idx, errors - errors_mark);
		end
		errors_mark = errors;
		beat_idx = 0;
		frames_done++;
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					$display("result beat arrived with no expected value left");
					errors++;
				end else begin
					check_result(result, exp_q.pop_front(), beat_idx);
				end
				check_flag("done", done, beat_idx == BEATS - 1);
				beat_idx++;
			end else begin
				check_flag("done", done, 1'b0);
			end
			if (done) report_frame();
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d frames finished",
				cycles, frames_done, NUM_TESTS);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		int total;
		rst = 1'b1;
		start = 1'b0;
		pixel_valid = 1'b0;
		pixel_in = '0;
		threshold = '0;
		//              kind       threshold  gap  idle
		tests[0] = '{IMG_FLAT, 11'd1, 0, 5};
		tests[1] = '{IMG_VSTEP, 11'd100, 0, 0};
		tests[2] = '{IMG_HSTEP, 11'd100, 0, 0};   // back to back with the row above.
		tests[3] = '{IMG_RAMP, 11'd20, 25, 3};
		tests[4] = '{IMG_NOISE, 11'd0, 0, 0};
		tests[5] = '{IMG_NOISE, 11'd2047, 30, 2};
		tests[6] = '{IMG_NOISE, 11'd500, 20, 0};
		tests[7] = '{IMG_FLAT, 11'd0, 10, 0};
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) total += W * H + tests[t].idle_pix;
		cycle_limit = 2 * total + 100 * NUM_TESTS;
		repeat (3) @(posedge clk);
		#5;
		rst = 1'b0;
		check_flag("result_valid", result_valid, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("busy", busy, 1'b0);
		for (int t = 0; t < NUM_TESTS; t++) run_frame(t);
		while (frames_done < NUM_TESTS) step();
		repeat (10) step();   // room for any stray beat.
		if (exp_q.size() != 0) begin
			$display("%0d expected result beats never arrived", exp_q.size());
			errors++;
		end
		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			pass_count, fail_count, errors);
		if (errors == 0 && fail_count == 0 && pass_count == NUM_TESTS) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* verilog/grad_conv.sv */
module grad_conv import sobel_pkg::*; #(
	parameter kernel_sel_t kernel = KERNEL_X
) (
	input logic clk,
	input logic rst,
	input win_beat_t win,
	output grad_beat_t grad
);

	typedef logic signed [9:0] prod_t;   // one pixel times a weight of at most 2.

	pixel_t [0:2][0:2] taps;
	prod_t prod [3][3];
	grad_t row_sum [3];
	grad_t total;
	logic valid1, valid2, valid3;
	logic last1, last2, last3;

	// sobel weight at row r and column c, both counted from the top left.
	function automatic prod_t weight(int r, int c);
		prod_t w;
		if (kernel == KERNEL_X) begin
			w = prod_t'((c - 1) * ((r == 1) ? 2 : 1));
		end else begin
			w = prod_t'((r - 1) * ((c == 1) ? 2 : 1));
		end
		return w;
	endfunction

	assign taps = win.window;   // taps[0][0] is the top left pixel.

	// ----------------------------------------
	// datapath
	// ----------------------------------------

	always_ff @(posedge clk) begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				prod[r][c] <= prod_t'(taps[r][c]) * weight(r, c);
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int r = 0; r < 3; r++) begin
			row_sum[r] <= grad_t'(prod[r][0]) + grad_t'(prod[r][1]) + grad_t'(prod[r][2]);
		end
	end

	// the final sum always fits, so the partial sums may wrap.
	always_ff @(posedge clk) begin
		total <= row_sum[0] + row_sum[1] + row_sum[2];
	end

	// ----------------------------------------
	// qualifiers
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			valid3 <= 1'b0;
			last1 <= 1'b0;
			last2 <= 1'b0;
			last3 <= 1'b0;
		end else begin
			valid1 <= win.valid;
			valid2 <= valid1;
			valid3 <= valid2;
			last1 <= win.last;
			last2 <= last1;
			last3 <= last2;
		end
	end

	assign grad = '{valid: valid3, last: last3, value: total};

endmodule

/* verilog/grad_magnitude.sv */
module grad_magnitude import sobel_pkg::*; (
	input logic clk,
	input logic rst,
	input grad_beat_t gx_beat,
	input grad_beat_t gy_beat,
	input logic [10:0] threshold,
	output edge_result_t result,
	output logic result_valid,
	output logic done
);

	logic [10:0] abs_x;
	logic [10:0] abs_y;
	logic [10:0] abs_sum;   // at most 2040.
	logic [7:0] mag_sat;
	logic edge_hit;

	assign abs_x = gx_beat.value[10] ? 11'(-gx_beat.value) : 11'(gx_beat.value);
	assign abs_y = gy_beat.value[10] ? 11'(-gy_beat.value) : 11'(gy_beat.value);
	assign abs_sum = abs_x + abs_y;

	assign mag_sat = (abs_sum > 11'd255) ? 8'hff : abs_sum[7:0];

	// the threshold sees the full sum and not the clipped one.
	assign edge_hit = (abs_sum >= threshold);

	// ----------------------------------------
	// output register
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (gx_beat.valid) begin
			result.gx <= gx_beat.value;
			result.gy <= gy_beat.value;
			result.magnitude <= mag_sat;
			result.is_edge <= edge_hit;
		end
	end

	// both convolvers have equal latency so the x qualifiers stand for both.
	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			result_valid <= gx_beat.valid;
			done <= gx_beat.valid && gx_beat.last;
		end
	end

endmodule

/* verilog/line_window.sv */
`include "sobel_macros.svh"

module line_window import sobel_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic pixel_valid,
	input pixel_t pixel_in,
	output win_beat_t win,
	output logic busy
);

	localparam int W = `SOBEL_IMG_WIDTH;
	localparam int H = `SOBEL_IMG_HEIGHT;
	localparam int XW = $clog2(W);
	localparam int YW = $clog2(H);

	frame_state_t state;
	frame_state_t state_next;
	logic [XW-1:0] cnt_x;
	logic [YW-1:0] cnt_y;
	logic accept;
	logic row_end;
	logic frame_end;

	pixel_t row_buf1 [W];   // previous row.
	pixel_t row_buf2 [W];   // row before that.
	pixel_t above1;
	pixel_t above2;

	function automatic win_row_t shift_row(win_row_t row, pixel_t px);
		win_row_t shifted;
		shifted.left = row.mid;
		shifted.mid = row.right;
		shifted.right = px;
		return shifted;
	endfunction

	// ----------------------------------------
	// frame control
	// ----------------------------------------

	assign accept = (state == PROCESSING) && pixel_valid;
	assign row_end = (cnt_x == XW'(W - 1));
	assign frame_end = row_end && (cnt_y == YW'(H - 1));
	assign busy = (state == PROCESSING);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (start) state_next = PROCESSING;
			PROCESSING: if (accept && frame_end) state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// the counters wrap to zero on the last pixel so each frame starts clean.
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_x <= '0;
			cnt_y <= '0;
		end else if (accept) begin
			if (row_end) begin
				cnt_x <= '0;
				cnt_y <= frame_end ? '0 : cnt_y + 1'b1;
			end else begin
				cnt_x <= cnt_x + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// row buffers
	// ----------------------------------------

	// each buffer is a full row deep, so its output is the same column one row up.
	assign above1 = row_buf1[W-1];
	assign above2 = row_buf2[W-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < W; i++) begin
				row_buf1[i] <= '0;
				row_buf2[i] <= '0;
			end
		end else if (accept) begin
			row_buf1[0] <= pixel_in;
			row_buf2[0] <= above1;   // second buffer is fed by the first.
			for (int i = 1; i < W; i++) begin
				row_buf1[i] <= row_buf1[i-1];
				row_buf2[i] <= row_buf2[i-1];
			end
		end
	end

	// ----------------------------------------
	// 3x3 window
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			win <= '0;
		end else begin
			win.valid <= accept && (cnt_x >= 2) && (cnt_y >= 2);   // interior centres only.
			win.last <= accept && frame_end;
			if (accept) begin
				win.window.top <= shift_row(win.window.top, above2);
				win.window.mid <= shift_row(win.window.mid, above1);
				win.window.bot <= shift_row(win.window.bot, pixel_in);
			end
		end
	end

endmodule

/* verilog/sobel_edge_top.sv */
module sobel_edge_top import sobel_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic pixel_valid,
	input pixel_t pixel_in,
	input logic [10:0] threshold,
	output edge_result_t result,
	output logic result_valid,
	output logic done,
	output logic busy
);

	win_beat_t win;
	grad_beat_t gx_beat;
	grad_beat_t gy_beat;

	line_window u_line_window (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.win(win),
		.busy(busy)
	);

	// both convolvers read the same window beat.
	grad_conv #(.kernel(KERNEL_X)) grad_x (
		.clk(clk),
		.rst(rst),
		.win(win),
		.grad(gx_beat)
	);

	grad_conv #(.kernel(KERNEL_Y)) grad_y (
		.clk(clk),
		.rst(rst),
		.win(win),
		.grad(gy_beat)
	);

	grad_magnitude u_grad_magnitude (
		.clk(clk),
		.rst(rst),
		.gx_beat(gx_beat),
		.gy_beat(gy_beat),
		.threshold(threshold),
		.result(result),
		.result_valid(result_valid),
		.done(done)
	);

endmodule

/* verilog/sobel_macros.svh */
`ifndef SOBEL_MACROS_SVH
`define SOBEL_MACROS_SVH

// ----------------------------------------
// frame geometry
// ----------------------------------------

// pixels in one image row.
`define SOBEL_IMG_WIDTH 32

// rows in one frame.
`define SOBEL_IMG_HEIGHT 32

// ----------------------------------------
// pixel format
// ----------------------------------------

// greyscale pixels are unsigned.
`define SOBEL_PIX_W 8

`endif

/* verilog/sobel_pkg.sv */
`include "sobel_macros.svh"

package sobel_pkg;

	typedef logic [`SOBEL_PIX_W-1:0] pixel_t;

	// one window row, oldest pixel on the left.
	typedef struct packed {
		pixel_t left;
		pixel_t mid;
		pixel_t right;
	} win_row_t;

	// top row is two rows above the newest pixel.
	typedef struct packed {
		win_row_t top;
		win_row_t mid;
		win_row_t bot;
	} window_t;

	typedef struct packed {
		logic valid;
		logic last;     // final neighbourhood of the frame.
		window_t window;
	} win_beat_t;

	typedef logic signed [10:0] grad_t;   // holds -1020 to 1020.

	typedef struct packed {
		logic valid;
		logic last;
		grad_t value;
	} grad_beat_t;

	typedef struct packed {
		grad_t gx;
		grad_t gy;
		logic [7:0] magnitude;
		logic is_edge;
	} edge_result_t;

	typedef enum logic {IDLE, PROCESSING} frame_state_t;

	typedef enum logic {KERNEL_X, KERNEL_Y} kernel_sel_t;

endpackage
